// ==== design/rv32_csr_pkg.sv ====
package rv32_csr_pkg;

    // ====================
    // addresses and ops
    // ====================

    // supported machine mode csr addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS   = 12'h300,
        CSR_MISA      = 12'h301,
        CSR_MIE       = 12'h304,
        CSR_MTVEC     = 12'h305,
        CSR_MEPC      = 12'h341,
        CSR_MCAUSE    = 12'h342,
        CSR_MTVAL     = 12'h343,
        CSR_MIP       = 12'h344,
        CSR_MCYCLE    = 12'hB00,
        CSR_MCYCLEH   = 12'hB80,
        CSR_MVENDORID = 12'hF11,
        CSR_MARCHID   = 12'hF12,
        CSR_MIMPID    = 12'hF13,
        CSR_MHARTID   = 12'hF14
    } csr_addr_e;

    // access kind issued by the core
    typedef enum logic [2:0] {
        CSR_OP_NONE  = 3'd0,
        CSR_OP_RW    = 3'd1,
        CSR_OP_SET   = 3'd2,
        CSR_OP_CLEAR = 3'd3,
        CSR_OP_MRET  = 3'd4
    } csr_op_e;

    // mvu view of an address: window prefix and offset within it
    typedef struct packed {
        logic [3:0] prefix;
        logic [7:0] offset;
    } mvu_addr_t;

    // one address word, two decodings
    typedef union packed {
        csr_addr_e std;
        mvu_addr_t mvu;
    } csr_addr_u;

    // ====================
    // register layouts
    // ====================

    // only mie, mpie and mpp are kept
    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    // core side access, one per cycle
    typedef struct packed {
        csr_addr_u   addr;
        logic [31:0] wdata;
        csr_op_e     op;
    } csr_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] cause;
    } exception_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } irq_evt_t;

    // write selects from the address decoder
    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mtvec;
        logic mepc;
        logic mtval;
        logic mip;
        logic mvu;
    } csr_sel_t;

    // current regfile contents, fed back for reads
    typedef struct packed {
        mstatus_t    mstatus;
        logic [31:0] mie;
        logic [31:0] mip;
        logic [31:0] mtvec;
        logic [31:0] mepc;
        logic [31:0] mcause;
        logic [31:0] mtval;
        logic [63:0] mcycle;
    } csr_state_t;

    // ====================
    // constants
    // ====================
    localparam logic [31:0] MARCHID_VAL   = 32'h0000_0019;
    // rv32i, mxl = 1
    localparam logic [31:0] MISA_VAL      = 32'h4000_0100;
    localparam logic [31:0] ILLEGAL_INSTR = 32'd2;

    // interrupt bit positions in mip and mie
    localparam int unsigned IRQ_M_SOFT  = 3;
    localparam int unsigned IRQ_M_TIMER = 7;
    localparam int unsigned IRQ_M_EXT   = 11;
    localparam int unsigned IRQ_MVU     = 16;

    localparam logic [31:0] IRQ_MASK = (32'd1 << IRQ_M_SOFT) | (32'd1 << IRQ_M_TIMER)
                                     | (32'd1 << IRQ_M_EXT) | (32'd1 << IRQ_MVU);

endpackage

// ==== design/mvu_apb_pkg.sv ====
package mvu_apb_pkg;

    // ====================
    // apb write port
    // ====================
    localparam int unsigned APB_ADDR_W = 12;
    localparam int unsigned APB_DATA_W = 32;

    // write only, no pready
    typedef struct packed {
        logic [APB_ADDR_W-1:0] paddr;
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    // ====================
    // mvu window
    // ====================

    // default first address of the mvu csr window
    // window runs from the base up to 0xfff
    localparam logic [11:0] MVU_WINDOW_DEFAULT = 12'hF20;

endpackage

// ==== design/csr_op_decode.sv ====
module csr_op_decode import rv32_csr_pkg::*; (
    input  csr_op_e     op_i,
    input  logic [31:0] wdata_i,
    input  logic [31:0] old_i,
    output logic        rd_en_o,
    output logic        we_o,
    output logic        mret_o,
    output logic [31:0] wdata_o
);

    always_comb begin
        // default is no access
        rd_en_o = 1'b0;
        we_o    = 1'b0;
        mret_o  = 1'b0;
        wdata_o = wdata_i;

        case (op_i)
            CSR_OP_RW: begin
                rd_en_o = 1'b1;
                we_o    = 1'b1;
            end
            // set bits on top of current value
            CSR_OP_SET: begin
                rd_en_o = 1'b1;
                we_o    = 1'b1;
                wdata_o = old_i | wdata_i;
            end
            // clear bits out of current value
            CSR_OP_CLEAR: begin
                rd_en_o = 1'b1;
                we_o    = 1'b1;
                wdata_o = old_i & ~wdata_i;
            end
            // return has no read or write side effect
            CSR_OP_MRET: begin
                mret_o = 1'b1;
            end
            default: begin
                rd_en_o = 1'b0;
                we_o    = 1'b0;
            end
        endcase
    end

endmodule

// ==== design/csr_addr_decode.sv ====
module csr_addr_decode import rv32_csr_pkg::*; #(
    parameter logic [31:0] HART_ID      = 32'd0,
    parameter logic [11:0] MVU_CSR_BASE = 12'hF20
) (
    input  csr_addr_u   addr_i,
    input  logic        rd_en_i,
    input  logic        we_i,
    input  csr_state_t  state_i,
    output csr_sel_t    sel_o,
    output logic [31:0] rdata_o,
    output exception_t  exception_o
);

    // window base split the same way as the address
    localparam mvu_addr_t WIN_BASE = mvu_addr_t'(MVU_CSR_BASE);

    logic        in_window;
    logic        known;
    logic        read_only;
    logic        rd_fault;
    logic        wr_fault;
    logic [31:0] rdata_raw;
    csr_sel_t    sel_raw;

    // ====================
    // window test
    // ====================

    // prefix first, offset only matters within the base prefix
    assign in_window = (addr_i.mvu.prefix > WIN_BASE.prefix)
                     || ((addr_i.mvu.prefix == WIN_BASE.prefix)
                         && (addr_i.mvu.offset >= WIN_BASE.offset));

    // ====================
    // register select
    // ====================
    always_comb begin
        known     = 1'b1;
        read_only = 1'b0;
        rdata_raw = '0;
        sel_raw   = '0;

        if (in_window) begin
            // mvu window reads as zero
            sel_raw.mvu = 1'b1;
        end else begin
            case (addr_i.std)
                // identity, read only
                CSR_MVENDORID: read_only = 1'b1;
                CSR_MIMPID:    read_only = 1'b1;
                CSR_MARCHID: begin
                    read_only = 1'b1;
                    rdata_raw = MARCHID_VAL;
                end
                CSR_MHARTID: begin
                    read_only = 1'b1;
                    rdata_raw = HART_ID;
                end
                // writes dropped silently
                CSR_MISA: rdata_raw = MISA_VAL;
                CSR_MSTATUS: begin
                    rdata_raw       = state_i.mstatus;
                    sel_raw.mstatus = 1'b1;
                end
                CSR_MIE: begin
                    rdata_raw   = state_i.mie;
                    sel_raw.mie = 1'b1;
                end
                CSR_MTVEC: begin
                    rdata_raw     = state_i.mtvec;
                    sel_raw.mtvec = 1'b1;
                end
                CSR_MEPC: begin
                    rdata_raw    = state_i.mepc;
                    sel_raw.mepc = 1'b1;
                end
                CSR_MTVAL: begin
                    rdata_raw     = state_i.mtval;
                    sel_raw.mtval = 1'b1;
                end
                CSR_MIP: begin
                    rdata_raw   = state_i.mip;
                    sel_raw.mip = 1'b1;
                end
                // only written by hardware
                CSR_MCAUSE: begin
                    read_only = 1'b1;
                    rdata_raw = state_i.mcause;
                end
                CSR_MCYCLE: begin
                    read_only = 1'b1;
                    rdata_raw = state_i.mcycle[31:0];
                end
                CSR_MCYCLEH: begin
                    read_only = 1'b1;
                    rdata_raw = state_i.mcycle[63:32];
                end
                default: known = 1'b0;
            endcase
        end
    end

    // ====================
    // access faults
    // ====================
    assign rd_fault = rd_en_i & ~known;
    assign wr_fault = we_i & (~known | read_only);

    assign rdata_o = rd_en_i ? rdata_raw : '0;
    assign sel_o   = we_i ? sel_raw : '0;

    // read and write faults give the same exception
    assign exception_o.valid = rd_fault | wr_fault;
    assign exception_o.cause = (rd_fault | wr_fault) ? ILLEGAL_INSTR : '0;

endmodule

// ==== design/csr_regfile.sv ====
module csr_regfile import rv32_csr_pkg::*; import mvu_apb_pkg::*; #(
    parameter logic [31:0] BOOT_ADDR = 32'h0000_0080
) (
    input  logic        clk,
    input  logic        rst_n,
    input  csr_sel_t    sel_i,
    input  logic [31:0] wdata_i,
    input  logic [11:0] addr_i,
    input  logic        mret_i,
    input  logic        irq_i,
    input  logic        time_irq_i,
    input  logic        ipi_i,
    input  logic        mvu_irq_i,
    input  logic [31:0] pc_i,
    input  logic [4:0]  cause_i,
    input  logic        enable_cycle_count_i,
    output csr_state_t  state_o,
    output irq_evt_t    irq_evt_o,
    output apb_req_t    apb_o
);

    mstatus_t    mstatus_q, mstatus_d;
    mstatus_t    mstatus_w;
    logic [31:0] mie_q, mie_d;
    logic [31:0] mip_q, mip_d;
    logic [31:0] mtvec_q, mtvec_d;
    logic [31:0] mepc_q, mepc_d;
    logic [31:0] mcause_q, mcause_d;
    logic [31:0] mtval_q, mtval_d;
    logic [63:0] mcycle_q, mcycle_d;
    // interrupt capture
    logic        irq_taken;
    logic        serviced_q, serviced_d;
    // apb write stage
    logic        apb_pulse_q;
    logic [11:0] apb_paddr_q;
    logic [31:0] apb_pwdata_q;

    // write data seen through the mstatus layout
    assign mstatus_w = mstatus_t'(wdata_i);

    // only the mvu source can be taken
    assign irq_taken = mstatus_q.mie & mip_q[IRQ_MVU] & mie_q[IRQ_MVU];

    // ====================
    // next state
    // ====================
    always_comb begin
        mstatus_d  = mstatus_q;
        mie_d      = mie_q;
        mtvec_d    = mtvec_q;
        mepc_d     = mepc_q;
        mcause_d   = mcause_q;
        mtval_d    = mtval_q;
        serviced_d = irq_taken;

        // free running while enabled
        mcycle_d = enable_cycle_count_i ? mcycle_q + 64'd1 : mcycle_q;

        // masked software writes
        if (sel_i.mstatus) begin
            mstatus_d      = '0;
            mstatus_d.mie  = mstatus_w.mie;
            mstatus_d.mpie = mstatus_w.mpie;
            mstatus_d.mpp  = mstatus_w.mpp;
        end
        if (sel_i.mie) begin
            mie_d = wdata_i & IRQ_MASK;
        end
        if (sel_i.mtvec) begin
            mtvec_d = wdata_i;
        end
        if (sel_i.mepc) begin
            mepc_d = {wdata_i[31:1], 1'b0};
        end
        if (sel_i.mtval) begin
            mtval_d = wdata_i;
        end

        // pending bits, line copies plus sticky mvu bit
        mip_d              = '0;
        mip_d[IRQ_M_SOFT]  = ipi_i;
        mip_d[IRQ_M_TIMER] = time_irq_i;
        mip_d[IRQ_M_EXT]   = irq_i;
        mip_d[IRQ_MVU]     = sel_i.mip ? wdata_i[IRQ_MVU] : (mip_q[IRQ_MVU] | mvu_irq_i);

        // interrupt entry
        if (irq_taken) begin
            mcause_d       = {1'b1, 26'b0, cause_i};
            mstatus_d.mpie = mstatus_q.mie;
            // return pc only on first taken cycle
            if (!serviced_q) begin
                mepc_d = pc_i;
            end
        end

        // machine return restores enables
        if (mret_i) begin
            mstatus_d.mie  = mstatus_q.mpie;
            mstatus_d.mpie = 1'b1;
            serviced_d     = 1'b0;
        end
    end

    // ====================
    // registers
    // ====================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q   <= '0;
            mie_q       <= '0;
            mip_q       <= '0;
            mtvec_q     <= BOOT_ADDR;
            mepc_q      <= '0;
            mcause_q    <= '0;
            mtval_q     <= '0;
            mcycle_q    <= '0;
            serviced_q  <= 1'b0;
            apb_pulse_q <= 1'b0;
        end else begin
            mstatus_q   <= mstatus_d;
            mie_q       <= mie_d;
            mip_q       <= mip_d;
            mtvec_q     <= mtvec_d;
            mepc_q      <= mepc_d;
            mcause_q    <= mcause_d;
            mtval_q     <= mtval_d;
            mcycle_q    <= mcycle_d;
            serviced_q  <= serviced_d;
            // one cycle pulse per window write
            apb_pulse_q <= sel_i.mvu;
        end
    end

    // address and data of the last window write
    always_ff @(posedge clk) begin
        if (sel_i.mvu) begin
            apb_paddr_q  <= addr_i;
            apb_pwdata_q <= wdata_i;
        end
    end

    // ====================
    // outputs
    // ====================
    assign state_o.mstatus = mstatus_q;
    assign state_o.mie     = mie_q;
    assign state_o.mip     = mip_q;
    assign state_o.mtvec   = mtvec_q;
    assign state_o.mepc    = mepc_q;
    assign state_o.mcause  = mcause_q;
    assign state_o.mtval   = mtval_q;
    assign state_o.mcycle  = mcycle_q;

    // any pending source with global enable
    assign irq_evt_o.valid  = (|mip_q) & mstatus_q.mie;
    assign irq_evt_o.target = mret_i ? mepc_q : mtvec_q;

    assign apb_o.paddr   = apb_paddr_q;
    assign apb_o.psel    = apb_pulse_q;
    assign apb_o.penable = apb_pulse_q;
    assign apb_o.pwrite  = apb_pulse_q;
    assign apb_o.pwdata  = apb_pwdata_q;

endmodule

// ==== design/csr_unit_top.sv ====
module csr_unit_top import rv32_csr_pkg::*; import mvu_apb_pkg::*; #(
    parameter logic [31:0] HART_ID      = 32'd0,
    parameter logic [31:0] BOOT_ADDR    = 32'h0000_0080,
    parameter logic [11:0] MVU_CSR_BASE = MVU_WINDOW_DEFAULT
) (
    input  logic        clk,
    input  logic        rst_n,
    // core access port
    input  csr_req_t    csr_req_i,
    output logic [31:0] csr_rdata_o,
    output exception_t  csr_exception_o,
    // interrupt lines
    input  logic        irq_i,
    input  logic        time_irq_i,
    input  logic        ipi_i,
    input  logic        mvu_irq_i,
    input  logic [31:0] pc_i,
    input  logic [4:0]  cause_i,
    input  logic        enable_cycle_count_i,
    output irq_evt_t    irq_evt_o,
    // mvu configuration writes
    output apb_req_t    apb_o
);

    logic        rd_en;
    logic        we;
    logic        mret;
    logic [31:0] wdata;
    logic [31:0] rdata;
    csr_sel_t    sel;
    csr_state_t  state;

    assign csr_rdata_o = rdata;

    // ====================
    // decode
    // ====================
    csr_op_decode u_op_decode (
        .op_i    (csr_req_i.op),
        .wdata_i (csr_req_i.wdata),
        .old_i   (rdata),
        .rd_en_o (rd_en),
        .we_o    (we),
        .mret_o  (mret),
        .wdata_o (wdata)
    );

    csr_addr_decode #(
        .HART_ID      (HART_ID),
        .MVU_CSR_BASE (MVU_CSR_BASE)
    ) u_addr_decode (
        .addr_i      (csr_req_i.addr),
        .rd_en_i     (rd_en),
        .we_i        (we),
        .state_i     (state),
        .sel_o       (sel),
        .rdata_o     (rdata),
        .exception_o (csr_exception_o)
    );

    // ====================
    // state
    // ====================
    csr_regfile #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_regfile (
        .clk                  (clk),
        .rst_n                (rst_n),
        .sel_i                (sel),
        .wdata_i              (wdata),
        .addr_i               (csr_req_i.addr),
        .mret_i               (mret),
        .irq_i                (irq_i),
        .time_irq_i           (time_irq_i),
        .ipi_i                (ipi_i),
        .mvu_irq_i            (mvu_irq_i),
        .pc_i                 (pc_i),
        .cause_i              (cause_i),
        .enable_cycle_count_i (enable_cycle_count_i),
        .state_o              (state),
        .irq_evt_o            (irq_evt_o),
        .apb_o                (apb_o)
    );

endmodule

// ==== verif/csr_unit_sva.sv ====
module csr_unit_sva import rv32_csr_pkg::*; import mvu_apb_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input csr_req_t   req_i,
    input exception_t exception_i,
    input apb_req_t   apb_i
);

    // ====================
    // apb pulse shape
    // ====================

    // write only port, all three strobes move together
    apb_strobes_match: assert property (@(posedge clk) disable iff (!rst_n)
        (apb_i.psel == apb_i.penable) && (apb_i.psel == apb_i.pwrite))
        else $error("apb strobes out of step");

    // nothing left over from reset
    apb_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !apb_i.psel && !apb_i.penable && !apb_i.pwrite)
        else $error("apb active right after reset release");

    // ====================
    // core side
    // ====================

    // mret has no read or write side
    mret_no_exception: assert property (@(posedge clk) disable iff (!rst_n)
        (req_i.op == CSR_OP_MRET) |-> !exception_i.valid)
        else $error("exception raised on an mret cycle");

endmodule

bind csr_unit_top csr_unit_sva u_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (csr_req_i),
    .exception_i (csr_exception_o),
    .apb_i       (apb_o)
);

// ==== verif/csr_unit_tb.sv ====
module csr_unit_tb import rv32_csr_pkg::*; import mvu_apb_pkg::*; ();

    localparam logic [31:0] TB_HART_ID   = 32'h0000_0005;
    localparam logic [31:0] TB_BOOT_ADDR = 32'h0000_4000;
    localparam int unsigned IRQ_TIMEOUT  = 20;

    logic        clk;
    logic        rst_n;
    csr_req_t    csr_req;
    logic        irq;
    logic        time_irq;
    logic        ipi;
    logic        mvu_irq;
    logic [31:0] pc;
    logic [4:0]  cause;
    logic        en_cnt;
    logic [31:0] rdata;
    exception_t  exc;
    irq_evt_t    irq_evt;
    apb_req_t    apb;

    // reference model state
    logic [31:0] m_mstatus;
    logic [31:0] m_mie;
    logic [31:0] m_mip;
    logic [31:0] m_mtvec;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [63:0] m_mcycle;
    logic        m_serviced;
    // apb write expected on the current cycle
    logic        m_apb_pend;
    logic [11:0] m_apb_addr;
    logic [31:0] m_apb_data;

    logic [31:0] rng;
    logic [31:0] last_rdata;
    int          checks;
    int          errors;

    csr_unit_top #(
        .HART_ID   (TB_HART_ID),
        .BOOT_ADDR (TB_BOOT_ADDR)
    ) dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .csr_req_i            (csr_req),
        .csr_rdata_o          (rdata),
        .csr_exception_o      (exc),
        .irq_i                (irq),
        .time_irq_i           (time_irq),
        .ipi_i                (ipi),
        .mvu_irq_i            (mvu_irq),
        .pc_i                 (pc),
        .cause_i              (cause),
        .enable_cycle_count_i (en_cnt),
        .irq_evt_o            (irq_evt),
        .apb_o                (apb)
    );

    always #5 clk = ~clk;

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    task automatic compare_val(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got, exp);
        end
    endtask

    // value a read should return, plus address class
    function automatic logic [31:0] expected_read(input logic [11:0] a, output logic known,
                                                  output logic ro);
        logic [31:0] v;
        known = 1'b1;
        v     = '0;
        // window reads as zero, never faults
        if (a >= MVU_WINDOW_DEFAULT) begin
            ro = 1'b0;
            return v;
        end
        case (a)
            12'h300: v = m_mstatus;
            12'h301: v = MISA_VAL;
            12'h304: v = m_mie;
            12'h305: v = m_mtvec;
            12'h341: v = m_mepc;
            12'h342: v = m_mcause;
            12'h343: v = m_mtval;
            12'h344: v = m_mip;
            12'hB00: v = m_mcycle[31:0];
            12'hB80: v = m_mcycle[63:32];
            12'hF11: v = 32'd0;
            12'hF12: v = MARCHID_VAL;
            12'hF13: v = 32'd0;
            12'hF14: v = TB_HART_ID;
            default: known = 1'b0;
        endcase
        // identity, counter and cause are not writable
        ro = (a == 12'h342) || (a == 12'hB00) || (a == 12'hB80) || (a[11:4] == 8'hF1);
        return v;
    endfunction

    // advance the model by one clock edge
    task automatic apply_model(input logic [2:0] op, input logic [11:0] a,
                               input logic [31:0] wd);
        logic [31:0] old;
        logic [31:0] nv;
        logic [31:0] old_ms;
        logic        known;
        logic        ro;
        logic        wr;
        logic        win;
        logic        taken;
        old    = expected_read(a, known, ro);
        wr     = (op == CSR_OP_RW) || (op == CSR_OP_SET) || (op == CSR_OP_CLEAR);
        win    = (a >= MVU_WINDOW_DEFAULT);
        old_ms = m_mstatus;
        taken  = m_mstatus[3] & m_mip[16] & m_mie[16];
        nv     = (op == CSR_OP_SET) ? (old | wd) : (op == CSR_OP_CLEAR) ? (old & ~wd) : wd;
        if (wr && !win) begin
            case (a)
                12'h300: m_mstatus = nv & 32'h0000_1888;
                12'h304: m_mie = nv & IRQ_MASK;
                12'h305: m_mtvec = nv;
                12'h341: m_mepc = {nv[31:1], 1'b0};
                12'h343: m_mtval = nv;
                default: ;
            endcase
        end
        // sticky mvu bit, line copies for the rest
        m_mip[16] = (wr && !win && a == 12'h344) ? nv[16] : (m_mip[16] | mvu_irq);
        m_mip[3]  = ipi;
        m_mip[7]  = time_irq;
        m_mip[11] = irq;
        if (taken) begin
            m_mcause     = {1'b1, 26'd0, cause};
            m_mstatus[7] = old_ms[3];
            if (!m_serviced) begin
                m_mepc = pc;
            end
        end
        m_serviced = taken;
        if (op == CSR_OP_MRET) begin
            m_mstatus[3] = old_ms[7];
            m_mstatus[7] = 1'b1;
            m_serviced   = 1'b0;
        end
        if (en_cnt) begin
            m_mcycle = m_mcycle + 64'd1;
        end
        m_apb_pend = wr && win;
        if (m_apb_pend) begin
            m_apb_addr = a;
            m_apb_data = nv;
        end
    endtask

    // one access, entered and left just after a rising edge
    task automatic run_cycle(input logic [2:0] op, input logic [11:0] a, input logic [31:0] wd);
        logic [31:0] raw;
        logic        known;
        logic        ro;
        logic        acc;
        logic        exp_exc;
        csr_req = {a, wd, op};
        #6;
        raw        = expected_read(a, known, ro);
        acc        = (op == CSR_OP_RW) || (op == CSR_OP_SET) || (op == CSR_OP_CLEAR);
        exp_exc    = acc && (!known || ro);
        last_rdata = rdata;
        compare_val("csr_rdata_o", rdata, acc ? raw : 32'd0);
        compare_val("csr_exception_o.valid", exc.valid, exp_exc);
        if (exp_exc) begin
            compare_val("csr_exception_o.cause", exc.cause, ILLEGAL_INSTR);
        end
        compare_val("irq_evt_o.valid", irq_evt.valid, (|m_mip) & m_mstatus[3]);
        compare_val("irq_evt_o.target", irq_evt.target,
                    (op == CSR_OP_MRET) ? m_mepc : m_mtvec);
        compare_val("apb_o.psel", apb.psel, m_apb_pend);
        compare_val("apb_o.penable", apb.penable, m_apb_pend);
        compare_val("apb_o.pwrite", apb.pwrite, m_apb_pend);
        if (m_apb_pend) begin
            compare_val("apb_o.paddr", apb.paddr, m_apb_addr);
            compare_val("apb_o.pwdata", apb.pwdata, m_apb_data);
        end
        apply_model(op, a, wd);
        @(posedge clk);
        #1;
    endtask

    // idle until the interrupt event shows up
    task automatic wait_for_irq(input int limit);
        int n;
        n = 0;
        while (!irq_evt.valid && n < limit) begin
            run_cycle(CSR_OP_NONE, 12'h000, 32'd0);
            n++;
        end
        if (!irq_evt.valid) begin
            $display("timeout: interrupt event never went valid after the mvu pulse");
            $display("Finished with errors");
            $finish;
        end
    endtask

    // ====================
    // stimulus
    // ====================
    initial begin
        logic [11:0] a;
        logic        known;
        logic        ro;
        logic [63:0] c0;
        logic [63:0] c1;
        int          n_en;
        int          i;

        clk      = 1'b0;
        rst_n    = 1'b0;
        csr_req  = '0;
        irq      = 1'b0;
        time_irq = 1'b0;
        ipi      = 1'b0;
        mvu_irq  = 1'b0;
        pc       = 32'h0000_1234;
        cause    = 5'd16;
        en_cnt   = 1'b0;
        rng      = 32'h6986_dedc;
        checks   = 0;
        errors   = 0;
        // reset values
        m_mstatus  = '0;
        m_mie      = '0;
        m_mip      = '0;
        m_mtvec    = TB_BOOT_ADDR;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        m_mcycle   = '0;
        m_serviced = 1'b0;
        m_apb_pend = 1'b0;
        m_apb_addr = '0;
        m_apb_data = '0;

        repeat (2) @(posedge clk);
        #1;
        rst_n  = 1'b1;
        en_cnt = 1'b1;

        // identity and reset values
        run_cycle(CSR_OP_SET, 12'hF11, 32'd0);
        run_cycle(CSR_OP_SET, 12'hF12, 32'd0);
        run_cycle(CSR_OP_SET, 12'hF13, 32'd0);
        run_cycle(CSR_OP_SET, 12'hF14, 32'd0);
        run_cycle(CSR_OP_SET, 12'h301, 32'd0);
        run_cycle(CSR_OP_SET, 12'h305, 32'd0);

        // random rw, set, clear on writable csrs
        for (i = 0; i < 300; i++) begin
            case (next_rand() % 6)
                0: a = 12'h300;
                1: a = 12'h304;
                2: a = 12'h305;
                3: a = 12'h341;
                4: a = 12'h343;
                default: a = 12'h344;
            endcase
            irq      = 1'(next_rand());
            time_irq = 1'(next_rand());
            ipi      = 1'(next_rand());
            run_cycle(3'd1 + 3'(next_rand() % 3), a, next_rand());
        end
        irq      = 1'b0;
        time_irq = 1'b0;
        ipi      = 1'b0;

        // unknown addresses fault
        for (i = 0; i < 60; i++) begin
            a = 12'(next_rand());
            void'(expected_read(a, known, ro));
            if (!known) begin
                run_cycle(CSR_OP_RW, a, next_rand());
            end
        end
        // read only targets fault on write
        run_cycle(CSR_OP_RW, 12'hF11, next_rand());
        run_cycle(CSR_OP_RW, 12'hF12, next_rand());
        run_cycle(CSR_OP_RW, 12'hF13, next_rand());
        run_cycle(CSR_OP_RW, 12'hF14, next_rand());
        run_cycle(CSR_OP_RW, 12'hB00, next_rand());
        run_cycle(CSR_OP_RW, 12'hB80, next_rand());
        run_cycle(CSR_OP_RW, 12'h342, next_rand());
        // misa write dropped quietly
        run_cycle(CSR_OP_RW, 12'h301, next_rand());
        run_cycle(CSR_OP_SET, 12'h301, 32'd0);

        // mvu window writes, some back to back
        for (i = 0; i < 60; i++) begin
            a = MVU_WINDOW_DEFAULT + 12'(next_rand() % 32'h0E0);
            run_cycle(3'd1 + 3'(next_rand() % 3), a, next_rand());
            if (next_rand() % 4 == 0) begin
                run_cycle(CSR_OP_NONE, 12'h000, 32'd0);
            end
        end
        run_cycle(CSR_OP_NONE, 12'h000, 32'd0);

        // ====================
        // interrupt and mret
        // ====================
        run_cycle(CSR_OP_RW, 12'h344, 32'd0);
        run_cycle(CSR_OP_RW, 12'h300, 32'd0);
        run_cycle(CSR_OP_RW, 12'h305, 32'h0000_8000);
        run_cycle(CSR_OP_RW, 12'h304, 32'h0001_0000);
        run_cycle(CSR_OP_RW, 12'h300, 32'h0000_0008);
        pc      = next_rand();
        cause   = 5'(next_rand());
        mvu_irq = 1'b1;
        run_cycle(CSR_OP_NONE, 12'h000, 32'd0);
        mvu_irq = 1'b0;
        wait_for_irq(IRQ_TIMEOUT);
        compare_val("irq_evt_o.target", irq_evt.target, 32'h0000_8000);
        // first taken cycle captures pc
        run_cycle(CSR_OP_SET, 12'h344, 32'd0);
        // later pc must not reach mepc
        pc = next_rand();
        run_cycle(CSR_OP_SET, 12'h342, 32'd0);
        run_cycle(CSR_OP_SET, 12'h341, 32'd0);
        // stop taking, then mie set and mpie clear so both mret effects show
        run_cycle(CSR_OP_RW, 12'h304, 32'd0);
        run_cycle(CSR_OP_RW, 12'h300, 32'h0000_0008);
        run_cycle(CSR_OP_MRET, 12'h000, 32'd0);
        run_cycle(CSR_OP_SET, 12'h300, 32'd0);
        compare_val("mstatus.mpie", last_rdata[7], 1'b1);
        compare_val("mstatus.mie", last_rdata[3], 1'b0);
        run_cycle(CSR_OP_RW, 12'h344, 32'd0);
        run_cycle(CSR_OP_RW, 12'h300, 32'd0);

        // counter delta over random enables
        en_cnt = 1'b0;
        run_cycle(CSR_OP_SET, 12'hB00, 32'd0);
        c0[31:0] = last_rdata;
        run_cycle(CSR_OP_SET, 12'hB80, 32'd0);
        c0[63:32] = last_rdata;
        n_en = 0;
        for (i = 0; i < 60; i++) begin
            en_cnt = 1'(next_rand());
            if (en_cnt) begin
                n_en++;
            end
            run_cycle(CSR_OP_NONE, 12'h000, 32'd0);
        end
        en_cnt = 1'b0;
        run_cycle(CSR_OP_SET, 12'hB00, 32'd0);
        c1[31:0] = last_rdata;
        run_cycle(CSR_OP_SET, 12'hB80, 32'd0);
        c1[63:32] = last_rdata;
        compare_val("mcycle delta", c1 - c0, 64'(n_en));

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== csr_unit.f ====
design/rv32_csr_pkg.sv
design/mvu_apb_pkg.sv
design/csr_op_decode.sv
design/csr_addr_decode.sv
design/csr_regfile.sv
design/csr_unit_top.sv
verif/csr_unit_sva.sv
verif/csr_unit_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		-f csr_unit.f --top-module csr_unit_tb -Mdir obj_dir
	./obj_dir/Vcsr_unit_tb | tee $(LOG)
	@grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
